//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dl_tx_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

//--- tb.f
verilog/dl_pkg.sv
verilog/dl_re_framer.sv
verilog/dl_pkt_buffer.sv
verilog/dl_iq_tx_pacer.sv
verilog/dl_tx_top.sv
tests/dl_tx_assertions.sv
tests/tb_dl_tx_top.sv

//--- tests/dl_tx_assertions.sv
`timescale 1ns/1ps

module dl_tx_assertions (
    input logic                      sys_clk_368_64,
    input logic                      sys_rst_491_52,
    input logic                      i_iq_tx_valid,
    input logic                      i_iq_tx_sop,
    input logic                      i_iq_tx_eop,
    input logic [dl_pkg::CHIP_W-1:0] i_iq_tx_chip_num,
    input logic                      i_rd_en,
    input logic                      i_wr_valid,
    input logic                      i_wr_eop,
    input logic                      i_credit,
    input logic                      i_pkt_ready
);

    import dl_pkg::*;

    // count of failed checks
    int fail_cnt = 0;

    // --------------------
    // reset state
    // --------------------
    reset_idle: assert property (@(posedge sys_clk_368_64)
        sys_rst_491_52 |=> !i_iq_tx_valid && !i_iq_tx_sop && !i_iq_tx_eop
                           && !i_rd_en && !i_wr_valid && !i_credit)
    else
    begin
        $error("output active in the cycle after reset");
        fail_cnt++;
    end

    // --------------------
    // burst framing
    // --------------------
    // sop only on the first valid word
    sop_first: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_sop |-> i_iq_tx_valid && !$past(i_iq_tx_valid))
    else
    begin
        $error("sop not on the first word of a burst");
        fail_cnt++;
    end

    start_has_sop: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_valid && !$past(i_iq_tx_valid) |-> i_iq_tx_sop)
    else
    begin
        $error("burst started without sop");
        fail_cnt++;
    end

    // eop closes a run of exactly PKT_WORDS valid cycles
    eop_length: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_eop |-> i_iq_tx_valid && $past(i_iq_tx_valid, PKT_WORDS - 1)
                        && !$past(i_iq_tx_valid, PKT_WORDS))
    else
    begin
        $error("eop not on word 48 of a burst");
        fail_cnt++;
    end

    no_gap: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_valid && !i_iq_tx_eop |=> i_iq_tx_valid)
    else
    begin
        $error("valid dropped before eop");
        fail_cnt++;
    end

    eop_ends: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_eop |=> !i_iq_tx_valid)
    else
    begin
        $error("valid still high after eop");
        fail_cnt++;
    end

    // chip number held through a burst
    chip_held: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_iq_tx_valid && $past(i_iq_tx_valid) |-> $stable(i_iq_tx_chip_num))
    else
    begin
        $error("chip number changed inside a burst");
        fail_cnt++;
    end

    // an eop write leaves a whole packet stored
    pkt_after_eop: assert property (@(posedge sys_clk_368_64) disable iff (sys_rst_491_52)
        i_wr_valid && i_wr_eop |=> i_pkt_ready)
    else
    begin
        $error("no complete packet flagged after an eop write");
        fail_cnt++;
    end

endmodule

bind dl_tx_top dl_tx_assertions dl_tx_assertions_inst (
    .sys_clk_368_64   (sys_clk_368_64),
    .sys_rst_491_52   (sys_rst_491_52),
    .i_iq_tx_valid    (o_iq_tx_valid),
    .i_iq_tx_sop      (o_iq_tx_sop),
    .i_iq_tx_eop      (o_iq_tx_eop),
    .i_iq_tx_chip_num (o_iq_tx_chip_num),
    .i_rd_en          (rd_en),
    .i_wr_valid       (wr_valid),
    .i_wr_eop         (wr_eop),
    .i_credit         (credit),
    .i_pkt_ready      (pkt_ready)
);

//--- tests/tb_dl_tx_top.sv
`timescale 1ns/1ps

module tb_dl_tx_top;

    import dl_pkg::*;

    // longest wait for one burst, hold may skip many opportunities
    localparam int WAIT_LIMIT = 64 * IQ_TX_PERIOD;

    logic              sys_clk_368_64;
    logic              sys_rst_491_52;
    logic              i_tx_hold;
    logic              o_iq_tx_valid;
    logic              o_iq_tx_sop;
    logic              o_iq_tx_eop;
    logic [WORD_W-1:0] o_iq_tx_data;
    logic [CHIP_W-1:0] o_iq_tx_chip_num;

    int cyc = 0;
    int seed = 32'hd6be1f51;
    bit rand_hold;
    bit timed_out;
    int test_errs;
    int tests_run;
    int tests_passed;
    int tests_failed;

    // reference indices of the next expected word
    int exp_re;
    int exp_prb;
    int exp_sym;
    int exp_slot;
    int exp_ant;
    int sym_wraps;

    // start cycle and chip of bursts
    int burst_start;
    int burst_chip;
    int first_start;
    int prev_start;
    int prev_chip;
    int release_cyc;

    dl_tx_top dl_tx_top_inst (
        .sys_clk_368_64   (sys_clk_368_64),
        .sys_rst_491_52   (sys_rst_491_52),
        .i_tx_hold        (i_tx_hold),
        .o_iq_tx_valid    (o_iq_tx_valid),
        .o_iq_tx_sop      (o_iq_tx_sop),
        .o_iq_tx_eop      (o_iq_tx_eop),
        .o_iq_tx_data     (o_iq_tx_data),
        .o_iq_tx_chip_num (o_iq_tx_chip_num)
    );

    // 4 ns period
    initial
    begin
        sys_clk_368_64 = 1'b0;
        forever #2 sys_clk_368_64 = ~sys_clk_368_64;
    end

    // rising edges seen so far
    always @(posedge sys_clk_368_64)
        cyc <= cyc + 1;

    // --------------------
    // reference model
    // --------------------
    // slot 63:56, symbol 55:52, prb 51:43, re 42:39, antenna group 38
    function automatic logic [WORD_W-1:0] expected_word();
        return {8'(exp_slot), 4'(exp_sym), 9'(exp_prb), 4'(exp_re), 1'(exp_ant), 38'd0};
    endfunction

    // re inside prb inside symbol inside slot
    function automatic void advance_model();
        exp_re = exp_re + 1;
        if (exp_re == RE_NUM)
        begin
            exp_re  = 0;
            exp_prb = exp_prb + 1;
            if (exp_prb == PRB_NUM)
            begin
                exp_prb   = 0;
                exp_ant   = 1 - exp_ant;
                sym_wraps = sym_wraps + 1;
                exp_sym   = exp_sym + 1;
                if (exp_sym == SYM_NUM)
                begin
                    exp_sym  = 0;
                    exp_slot = (exp_slot + 1) % 256;
                end
            end
        end
    endfunction

    // --------------------
    // helpers
    // --------------------
    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] exp_val, input logic [63:0] act_val);
        $display("** Error [%s] %s: expected %0h, actual %0h", test, what, exp_val, act_val);
        test_errs++;
    endtask

    task automatic report_problem(input string test, input string msg);
        $display("[%s] %s", test, msg);
        test_errs++;
    endtask

    // falling edge: outputs settled, hold input redriven
    task automatic step_cycle();
        int rnd;
        @(negedge sys_clk_368_64);
        rnd = $random(seed);
        i_tx_hold = rand_hold && rnd[0];
    endtask

    // waits for the next burst and checks framing and payload word by word
    task automatic collect_burst(input string test);
        int waited;
        int len;
        waited = 0;
        len    = 0;
        while (!o_iq_tx_valid && waited < WAIT_LIMIT)
        begin
            step_cycle();
            waited++;
        end
        if (!o_iq_tx_valid)
        begin
            report_problem(test, $sformatf("timeout, no burst within %0d cycles", WAIT_LIMIT));
            timed_out = 1'b1;
        end
        else
        begin
            burst_start = cyc;
            burst_chip  = int'(o_iq_tx_chip_num);
            while (o_iq_tx_valid && len <= PKT_WORDS)
            begin
                assert (o_iq_tx_sop == (len == 0))
                else report_mismatch(test, "sop", 64'(len == 0), 64'(o_iq_tx_sop));
                assert (o_iq_tx_eop == (len == PKT_WORDS - 1))
                else report_mismatch(test, "eop", 64'(len == PKT_WORDS - 1), 64'(o_iq_tx_eop));
                assert (o_iq_tx_data == expected_word())
                else report_mismatch(test, "payload", expected_word(), o_iq_tx_data);
                advance_model();
                len++;
                step_cycle();
            end
            assert (len == PKT_WORDS)
            else report_mismatch(test, "burst length", 64'(PKT_WORDS), 64'(len));
        end
    endtask

    // start spacing and chip numbering against the previous burst
    task automatic check_cadence(input string test, input bit hold_free);
        int gap;
        int exp_chip;
        gap = burst_start - prev_start;
        assert (gap >= IQ_TX_PERIOD)
        else report_problem(test, $sformatf("bursts only %0d cycles apart", gap));
        assert ((burst_start - first_start) % IQ_TX_PERIOD == 0)
        else report_mismatch(test, "start offset mod period", 64'(0),
                             64'((burst_start - first_start) % IQ_TX_PERIOD));
        // skipped opportunities still use a chip number
        if (hold_free)
            exp_chip = (prev_chip + 1) % 512;
        else
            exp_chip = (prev_chip + gap / IQ_TX_PERIOD) % 512;
        assert (burst_chip == exp_chip)
        else report_mismatch(test, "chip number", 64'(exp_chip), 64'(burst_chip));
        prev_start = burst_start;
        prev_chip  = burst_chip;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (test_errs == 0)
        begin
            tests_passed++;
            $display("test %s: passed", test);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test, test_errs);
        end
        test_errs = 0;
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial
    begin
        int bind_fails;
        sys_rst_491_52 = 1'b1;
        i_tx_hold      = 1'b0;
        rand_hold      = 1'b0;
        timed_out      = 1'b0;
        test_errs      = 0;
        tests_run      = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        exp_re         = 0;
        exp_prb        = 0;
        exp_sym        = 0;
        exp_slot       = 0;
        exp_ant        = 0;
        sym_wraps      = 0;
        repeat (3) @(posedge sys_clk_368_64);
        @(negedge sys_clk_368_64);

        // idle after reset, first burst START_DELAY+2 cycles after release
        assert (!o_iq_tx_valid && !o_iq_tx_sop && !o_iq_tx_eop)
        else report_problem("first_burst", "transmit outputs active during reset");
        sys_rst_491_52 = 1'b0;
        release_cyc    = cyc;
        collect_burst("first_burst");
        if (!timed_out)
        begin
            assert (burst_start - release_cyc == START_DELAY + 2)
            else report_mismatch("first_burst", "start cycle", 64'(START_DELAY + 2),
                                 64'(burst_start - release_cyc));
            assert (burst_chip == 0)
            else report_mismatch("first_burst", "chip number", 64'(0), 64'(burst_chip));
        end
        first_start = burst_start;
        prev_start  = burst_start;
        prev_chip   = burst_chip;
        finish_test("first_burst");

        // 100 bursts in all, past three symbol wraps
        if (!timed_out)
        begin
            for (int i = 0; i < 99 && !timed_out; i++)
            begin
                collect_burst("hold_low_stream");
                if (!timed_out)
                    check_cadence("hold_low_stream", 1'b1);
            end
            assert (sym_wraps >= 3)
            else report_problem("hold_low_stream", "fewer than three symbols were covered");
            finish_test("hold_low_stream");
        end

        // random hold, buffer fills and framer stalls
        if (!timed_out)
        begin
            rand_hold = 1'b1;
            for (int i = 0; i < 40 && !timed_out; i++)
            begin
                collect_burst("random_hold_stream");
                if (!timed_out)
                    check_cadence("random_hold_stream", 1'b0);
            end
            rand_hold = 1'b0;
            i_tx_hold = 1'b0;
            finish_test("random_hold_stream");
        end

        bind_fails = dl_tx_top_inst.dl_tx_assertions_inst.fail_cnt;
        $display("tests run %0d, passed %0d, failed %0d, bound assertion failures %0d",
                 tests_run, tests_passed, tests_failed, bind_fails);
        if (tests_failed == 0 && bind_fails == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog/dl_iq_tx_pacer.sv
`timescale 1ns/1ps

module dl_iq_tx_pacer (
    input  logic                      sys_clk_368_64,
    input  logic                      sys_rst_491_52,
    input  logic                      i_pkt_ready,
    input  logic                      i_tx_hold,
    input  logic [dl_pkg::WORD_W-1:0] i_rd_data,
    input  logic                      i_rd_sop,
    input  logic                      i_rd_eop,
    output logic                      o_rd_en,
    output logic                      o_iq_tx_valid,
    output logic                      o_iq_tx_sop,
    output logic                      o_iq_tx_eop,
    output logic [dl_pkg::WORD_W-1:0] o_iq_tx_data,
    output logic [dl_pkg::CHIP_W-1:0] o_iq_tx_chip_num
);

    import dl_pkg::*;

    logic [DLY_W-1:0]    dly_cnt;
    logic [PERIOD_W-1:0] period_cnt;
    logic [BURST_W-1:0]  burst_cnt;
    logic                burst_active;
    // read data valid from the buffer this cycle
    logic                rd_vld;

    logic start_done;
    logic tick;
    logic burst_go;

    assign start_done = (dly_cnt == DLY_W'(START_DELAY));
    // first tick at START_DELAY, then every IQ_TX_PERIOD
    assign tick       = start_done && (period_cnt == '0);
    // skip the opportunity when nothing whole is stored or on hold
    assign burst_go   = tick && i_pkt_ready && !i_tx_hold;
    assign o_rd_en    = burst_go || burst_active;

    // --------------------
    // period timing
    // --------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            dly_cnt          <= '0;
            period_cnt       <= '0;
            o_iq_tx_chip_num <= CHIP_W'(CHIP_RESET);
        end
        else
        begin
            // start delay saturates
            if (!start_done)
                dly_cnt <= dly_cnt + 1'b1;
            else if (period_cnt == PERIOD_W'(IQ_TX_PERIOD - 1))
                period_cnt <= '0;
            else
                period_cnt <= period_cnt + 1'b1;
            // skipped ticks still use a chip number
            if (tick)
                o_iq_tx_chip_num <= o_iq_tx_chip_num + 1'b1;
        end
    end

    // --------------------
    // burst read-out
    // --------------------
    // first word issued on the tick, 47 more follow
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            burst_active <= 1'b0;
            burst_cnt    <= '0;
        end
        else if (burst_go)
        begin
            burst_active <= 1'b1;
            burst_cnt    <= BURST_W'(1);
        end
        else if (burst_active)
        begin
            burst_cnt <= burst_cnt + 1'b1;
            if (burst_cnt == BURST_W'(PKT_WORDS - 1))
                burst_active <= 1'b0;
        end
    end

    // transmit registers, two cycles behind the tick
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            rd_vld        <= 1'b0;
            o_iq_tx_valid <= 1'b0;
            o_iq_tx_sop   <= 1'b0;
            o_iq_tx_eop   <= 1'b0;
        end
        else
        begin
            rd_vld        <= o_rd_en;
            o_iq_tx_valid <= rd_vld;
            o_iq_tx_sop   <= rd_vld && i_rd_sop;
            o_iq_tx_eop   <= rd_vld && i_rd_eop;
        end
    end

    always_ff @(posedge sys_clk_368_64)
    begin
        if (rd_vld)
            o_iq_tx_data <= i_rd_data;
    end

endmodule

//--- verilog/dl_pkg.sv
package dl_pkg;

    // --------------------
    // frame geometry
    // --------------------
    localparam int RE_NUM       = 12;
    localparam int PRB_NUM      = 132;
    localparam int SYM_NUM      = 14;
    localparam int PRB_PER_PKT  = 4;
    // 48 words, 33 packets per symbol
    localparam int PKT_WORDS    = RE_NUM * PRB_PER_PKT;

    // --------------------
    // packet buffer and credits
    // --------------------
    localparam int BUF_DEPTH    = 128;
    localparam int BUF_AW       = 7;
    localparam int CREDIT_W     = 8;
    // at most two whole packets fit in the store
    localparam int PKT_CNT_W    = $clog2(BUF_DEPTH / PKT_WORDS + 1);

    // --------------------
    // transmit pacing
    // --------------------
    localparam int IQ_TX_PERIOD = 96;
    localparam int START_DELAY  = 100;
    localparam int CHIP_W       = 9;
    localparam int CHIP_RESET   = 511;
    localparam int DLY_W        = $clog2(START_DELAY + 1);
    localparam int PERIOD_W     = $clog2(IQ_TX_PERIOD);
    localparam int BURST_W      = $clog2(PKT_WORDS);

    // --------------------
    // payload word layout
    // --------------------
    localparam int WORD_W       = 64;
    localparam int SLOT_W       = 8;
    localparam int SYM_W        = 4;
    localparam int PRB_W        = 9;
    localparam int RE_W         = 4;
    localparam int SLOT_LSB     = 56;
    localparam int SYM_LSB      = 52;
    localparam int PRB_LSB      = 43;
    localparam int RE_LSB       = 39;
    localparam int ANT_BIT      = 38;

    // index fields packed from the top, all other bits zero
    function automatic logic [WORD_W-1:0] build_re_word(
        input logic [SLOT_W-1:0] slot,
        input logic [SYM_W-1:0]  sym,
        input logic [PRB_W-1:0]  prb,
        input logic [RE_W-1:0]   re,
        input logic              ant_grp
    );
        logic [WORD_W-1:0] word;
        word = '0;
        word[SLOT_LSB +: SLOT_W] = slot;
        word[SYM_LSB +: SYM_W]   = sym;
        word[PRB_LSB +: PRB_W]   = prb;
        word[RE_LSB +: RE_W]     = re;
        word[ANT_BIT]            = ant_grp;
        return word;
    endfunction

endpackage

//--- verilog/dl_pkt_buffer.sv
`timescale 1ns/1ps

module dl_pkt_buffer (
    input  logic                      sys_clk_368_64,
    input  logic                      sys_rst_491_52,
    input  logic                      i_wr_valid,
    input  logic                      i_wr_sop,
    input  logic                      i_wr_eop,
    input  logic [dl_pkg::WORD_W-1:0] i_wr_data,
    input  logic                      i_rd_en,
    output logic [dl_pkg::WORD_W-1:0] o_rd_data,
    output logic                      o_rd_sop,
    output logic                      o_rd_eop,
    output logic                      o_pkt_ready,
    output logic                      o_credit
);

    import dl_pkg::*;

    // word store, eop in the top bit, sop below it
    logic [WORD_W+1:0]    mem [BUF_DEPTH];
    logic [BUF_AW-1:0]    wr_ptr;
    logic [BUF_AW-1:0]    rd_ptr;
    // whole packets held
    logic [PKT_CNT_W-1:0] pkt_cnt;

    logic wr_eop_now;
    logic rd_eop_now;

    assign wr_eop_now = i_wr_valid && i_wr_eop;
    // flag of the word leaving this cycle
    assign rd_eop_now = i_rd_en && mem[rd_ptr][WORD_W+1];

    // --------------------
    // store write
    // --------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (i_wr_valid)
            mem[wr_ptr] <= {i_wr_eop, i_wr_sop, i_wr_data};
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (i_wr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // --------------------
    // packet count
    // --------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
            pkt_cnt <= '0;
        else if (wr_eop_now && !rd_eop_now)
            pkt_cnt <= pkt_cnt + 1'b1;
        else if (!wr_eop_now && rd_eop_now)
            pkt_cnt <= pkt_cnt - 1'b1;
    end

    // high from the cycle after an eop write
    assign o_pkt_ready = (pkt_cnt != '0);

    // --------------------
    // read port
    // --------------------
    // one cycle latency
    always_ff @(posedge sys_clk_368_64)
    begin
        if (i_rd_en)
            o_rd_data <= mem[rd_ptr][WORD_W-1:0];
    end

    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            o_rd_sop <= 1'b0;
            o_rd_eop <= 1'b0;
        end
        else
        begin
            o_rd_sop <= i_rd_en && mem[rd_ptr][WORD_W];
            o_rd_eop <= rd_eop_now;
        end
    end

    // each word read frees a slot for the framer
    assign o_credit = i_rd_en;

endmodule

//--- verilog/dl_re_framer.sv
`timescale 1ns/1ps

module dl_re_framer (
    input  logic                      sys_clk_368_64,
    input  logic                      sys_rst_491_52,
    input  logic                      i_credit,
    output logic                      o_wr_valid,
    output logic [dl_pkg::WORD_W-1:0] o_wr_data,
    output logic                      o_wr_sop,
    output logic                      o_wr_eop
);

    import dl_pkg::*;

    // resource element indices
    logic [RE_W-1:0]     re_idx;
    logic [PRB_W-1:0]    prb_idx;
    logic [SYM_W-1:0]    sym_idx;
    logic [SLOT_W-1:0]   slot_idx;
    logic                ant_grp;
    // free slots left in the buffer
    logic [CREDIT_W-1:0] credit_cnt;

    logic emit;
    logic last_re;
    logic last_prb;
    logic last_sym;
    logic pkt_first;
    logic pkt_last;

    // one word per cycle while any credit is held
    assign emit      = (credit_cnt != '0);
    assign last_re   = (re_idx == RE_W'(RE_NUM - 1));
    assign last_prb  = (prb_idx == PRB_W'(PRB_NUM - 1));
    assign last_sym  = (sym_idx == SYM_W'(SYM_NUM - 1));
    // packet edges, four prbs each
    assign pkt_first = (re_idx == '0) && ((prb_idx % PRB_PER_PKT) == 0);
    assign pkt_last  = last_re && ((prb_idx % PRB_PER_PKT) == PRB_PER_PKT - 1);

    // --------------------
    // credit counter
    // --------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
            credit_cnt <= CREDIT_W'(BUF_DEPTH);
        else if (emit && !i_credit)
            credit_cnt <= credit_cnt - 1'b1;
        else if (!emit && i_credit)
            credit_cnt <= credit_cnt + 1'b1;
    end

    // --------------------
    // index nesting
    // --------------------
    // re inside prb inside symbol inside slot, frozen while stalled
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            re_idx   <= '0;
            prb_idx  <= '0;
            sym_idx  <= '0;
            slot_idx <= '0;
            ant_grp  <= 1'b0;
        end
        else if (emit)
        begin
            if (!last_re)
                re_idx <= re_idx + 1'b1;
            else
            begin
                re_idx <= '0;
                if (!last_prb)
                    prb_idx <= prb_idx + 1'b1;
                else
                begin
                    prb_idx <= '0;
                    // antenna group flips once per symbol
                    ant_grp <= ~ant_grp;
                    if (!last_sym)
                        sym_idx <= sym_idx + 1'b1;
                    else
                    begin
                        sym_idx  <= '0;
                        // 8 bit slot rolls over at 256
                        slot_idx <= slot_idx + 1'b1;
                    end
                end
            end
        end
    end

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge sys_clk_368_64)
    begin
        if (sys_rst_491_52)
        begin
            o_wr_valid <= 1'b0;
            o_wr_sop   <= 1'b0;
            o_wr_eop   <= 1'b0;
        end
        else
        begin
            o_wr_valid <= emit;
            o_wr_sop   <= emit && pkt_first;
            o_wr_eop   <= emit && pkt_last;
        end
    end

    // payload built from the current indices
    always_ff @(posedge sys_clk_368_64)
    begin
        if (emit)
            o_wr_data <= build_re_word(slot_idx, sym_idx, prb_idx, re_idx, ant_grp);
    end

endmodule

//--- verilog/dl_tx_top.sv
`timescale 1ns/1ps

module dl_tx_top (
    input  logic                      sys_clk_368_64,
    input  logic                      sys_rst_491_52,
    input  logic                      i_tx_hold,
    output logic                      o_iq_tx_valid,
    output logic                      o_iq_tx_sop,
    output logic                      o_iq_tx_eop,
    output logic [dl_pkg::WORD_W-1:0] o_iq_tx_data,
    output logic [dl_pkg::CHIP_W-1:0] o_iq_tx_chip_num
);

    import dl_pkg::*;

    // --------------------
    // framer to buffer
    // --------------------
    logic              wr_valid;
    logic [WORD_W-1:0] wr_data;
    logic              wr_sop;
    logic              wr_eop;
    logic              credit;

    // --------------------
    // buffer to pacer
    // --------------------
    logic              pkt_ready;
    logic              rd_en;
    logic [WORD_W-1:0] rd_data;
    logic              rd_sop;
    logic              rd_eop;

    // word source, gated by credits
    dl_re_framer dl_re_framer_inst (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .i_credit       (credit),
        .o_wr_valid     (wr_valid),
        .o_wr_data      (wr_data),
        .o_wr_sop       (wr_sop),
        .o_wr_eop       (wr_eop)
    );

    dl_pkt_buffer dl_pkt_buffer_inst (
        .sys_clk_368_64 (sys_clk_368_64),
        .sys_rst_491_52 (sys_rst_491_52),
        .i_wr_valid     (wr_valid),
        .i_wr_sop       (wr_sop),
        .i_wr_eop       (wr_eop),
        .i_wr_data      (wr_data),
        .i_rd_en        (rd_en),
        .o_rd_data      (rd_data),
        .o_rd_sop       (rd_sop),
        .o_rd_eop       (rd_eop),
        .o_pkt_ready    (pkt_ready),
        .o_credit       (credit)
    );

    // one packet per transmit opportunity
    dl_iq_tx_pacer dl_iq_tx_pacer_inst (
        .sys_clk_368_64   (sys_clk_368_64),
        .sys_rst_491_52   (sys_rst_491_52),
        .i_pkt_ready      (pkt_ready),
        .i_tx_hold        (i_tx_hold),
        .i_rd_data        (rd_data),
        .i_rd_sop         (rd_sop),
        .i_rd_eop         (rd_eop),
        .o_rd_en          (rd_en),
        .o_iq_tx_valid    (o_iq_tx_valid),
        .o_iq_tx_sop      (o_iq_tx_sop),
        .o_iq_tx_eop      (o_iq_tx_eop),
        .o_iq_tx_data     (o_iq_tx_data),
        .o_iq_tx_chip_num (o_iq_tx_chip_num)
    );

endmodule
